// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes of the supported RV32I subset.
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [1:0] {
        PC_NEXT,   // pc + 4.
        PC_BRANCH, // pc + offset.
        PC_JUMP,   // load target.
        PC_HOLD
    } pc_mode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // returns operand b, used by LUI.
    } alu_op_t;

endpackage

// ==== hdl/rv_decoder.sv ====
module rv_decoder import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_instr,
    input  word_t    instr,
    output opcode_t  opcode,
    output funct3_t  funct3,
    output logic     alt_bit,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm
);

    word_t ir;

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;
        end else if (load_instr) begin
            ir <= instr; // captured at the edge that leaves FETCH.
        end
    end

    assign opcode  = ir[6:0];
    assign funct3  = ir[14:12];
    assign alt_bit = ir[30]; // selects SUB and SRA.
    assign rs1     = ir[19:15];
    assign rs2     = ir[24:20];
    assign rd      = ir[11:7];

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP_IMM,
            OP_JALR,
            OP_LOAD:   imm = imm_i;
            OP_STORE:  imm = imm_s;
            OP_BRANCH: imm = imm_b;
            OP_LUI,
            OP_AUIPC:  imm = imm_u;
            OP_JAL:    imm = imm_j;
            default:   imm = '0; // R-type and unknown opcodes carry no immediate.
        endcase
    end

endmodule

// ==== hdl/rv_regfile.sv ====
module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr0,
    input  reg_idx_t raddr1,
    output word_t    rdata0,
    output word_t    rdata1
);

    word_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// ==== hdl/rv_alu.sv ====
module rv_alu import rv_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // only the low five bits count for RV32 shifts.

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// ==== hdl/rv_pc.sv ====
module rv_pc import rv_pkg::*; #(
    parameter addr_t start_addr = 32'h800
) (
    input  logic     clk,
    input  logic     rst,
    input  pc_mode_t pc_mode,
    input  word_t    offset,
    input  addr_t    target,
    output addr_t    pc,
    output addr_t    pc_plus4
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= start_addr;
        end else begin
            case (pc_mode)
                PC_NEXT:   pc <= pc_plus4;
                PC_BRANCH: pc <= pc + offset;
                PC_JUMP:   pc <= {target[31:1], 1'b0}; // JALR clears bit 0.
                default:   pc <= pc;
            endcase
        end
    end

    assign pc_plus4 = pc + 32'd4; // also the link value of JAL and JALR.

endmodule

// ==== hdl/rv_control.sv ====
module rv_control import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  opcode_t  opcode,
    input  funct3_t  funct3,
    input  logic     alt_bit,
    input  reg_idx_t rd,
    input  word_t    imm,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    input  addr_t    pc,
    input  addr_t    pc_plus4,
    input  word_t    alu_result,
    input  word_t    data_rdata,
    output logic     load_instr,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    output alu_op_t  alu_op,
    output word_t    alu_a,
    output word_t    alu_b,
    output pc_mode_t pc_mode,
    output addr_t    pc_target,
    output addr_t    data_addr,
    output word_t    data_wdata,
    output logic     data_store
);

    typedef enum logic [2:0] {
        S_HALT,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } state_t;

    state_t   state;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     is_jump;
    logic     writes_rd;
    logic     take_branch;
    alu_op_t  op_sel;
    word_t    a_sel;
    word_t    b_sel;
    word_t    wb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_HALT;
        end else begin
            case (state)
                S_HALT:      state <= S_FETCH;
                S_FETCH:     state <= S_DECODE;
                S_DECODE:    state <= S_EXECUTE;
                S_EXECUTE:   state <= S_MEMORY;
                S_MEMORY:    state <= S_WRITEBACK;
                default:     state <= S_FETCH;
            endcase
        end
    end

    assign load_instr = (state == S_FETCH);

    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_jump   = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign writes_rd = opcode inside {OP_REG, OP_IMM, OP_LUI, OP_AUIPC,
                                      OP_JAL, OP_JALR, OP_LOAD};

    always_comb begin
        op_sel = ALU_ADD; // address and link targets all add.
        case (opcode)
            OP_REG,
            OP_IMM: begin
                case (funct3)
                    3'b000:  op_sel = (opcode == OP_REG && alt_bit) ? ALU_SUB : ALU_ADD;
                    3'b001:  op_sel = ALU_SLL;
                    3'b010:  op_sel = ALU_SLT;
                    3'b011:  op_sel = ALU_SLTU;
                    3'b100:  op_sel = ALU_XOR;
                    3'b101:  op_sel = alt_bit ? ALU_SRA : ALU_SRL;
                    3'b110:  op_sel = ALU_OR;
                    default: op_sel = ALU_AND;
                endcase
            end
            OP_LUI: op_sel = ALU_PASS_B;
            OP_BRANCH: begin
                case (funct3)
                    F3_BLT, F3_BGE:   op_sel = ALU_SLT;
                    F3_BLTU, F3_BGEU: op_sel = ALU_SLTU;
                    default:          op_sel = ALU_SUB; // equality tests look for zero.
                endcase
            end
            default: op_sel = ALU_ADD;
        endcase
    end

    assign a_sel = (opcode == OP_AUIPC || opcode == OP_JAL) ? pc : rs1_val;
    assign b_sel = (opcode == OP_REG || opcode == OP_BRANCH) ? rs2_val : imm;

    always_comb begin
        case (funct3)
            F3_BEQ:           take_branch = (alu_result == '0);
            F3_BNE:           take_branch = (alu_result != '0);
            F3_BLT, F3_BLTU:  take_branch = alu_result[0];
            F3_BGE, F3_BGEU:  take_branch = !alu_result[0];
            default:          take_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == S_EXECUTE) begin
            alu_op <= op_sel;
            alu_a  <= a_sel;
            alu_b  <= b_sel;
        end
        if (state == S_MEMORY) begin
            data_addr  <= alu_result;
            data_wdata <= rs2_val;
            pc_target  <= alu_result; // jump target of JAL and JALR.
            rf_waddr   <= rd;
            wb_q       <= is_jump ? pc_plus4 : alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we      <= 1'b0;
            data_store <= 1'b0;
            pc_mode    <= PC_HOLD;
        end else if (state == S_MEMORY) begin
            rf_we      <= writes_rd;
            data_store <= is_store;
            if (is_branch && take_branch) begin
                pc_mode <= PC_BRANCH;
            end else if (is_jump) begin
                pc_mode <= PC_JUMP;
            end else begin
                pc_mode <= PC_NEXT;
            end
        end else begin
            rf_we      <= 1'b0;
            data_store <= 1'b0;
            pc_mode    <= PC_HOLD;
        end
    end

    // load data arrives in WRITEBACK, once data_addr is settled.
    assign rf_wdata = is_load ? data_rdata : wb_q;

endmodule

// ==== hdl/rv_multi_cycle_core.sv ====
module rv_multi_cycle_core import rv_pkg::*; #(
    parameter addr_t start_addr = 32'h800
) (
    input  logic  clk,
    input  logic  rst,
    output addr_t instr_addr,
    input  word_t instr,
    output addr_t data_addr,
    output word_t data_wdata,
    output logic  data_store,
    input  word_t data_rdata
);

    pc_mode_t pc_mode;
    addr_t    pc_target;
    addr_t    pc_plus4;
    logic     load_instr;
    opcode_t  opcode;
    funct3_t  funct3;
    logic     alt_bit;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    word_t    rs1_val;
    word_t    rs2_val;
    alu_op_t  alu_op;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;

    rv_pc #(.start_addr(start_addr)) rv_pc_i (
        .clk(clk), .rst(rst), .pc_mode(pc_mode), .offset(imm),
        .target(pc_target), .pc(instr_addr), .pc_plus4(pc_plus4)
    );

    rv_decoder rv_decoder_i (
        .clk(clk), .rst(rst), .load_instr(load_instr), .instr(instr),
        .opcode(opcode), .funct3(funct3), .alt_bit(alt_bit),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm)
    );

    rv_regfile rv_regfile_i (
        .clk(clk), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr0(rs1), .raddr1(rs2), .rdata0(rs1_val), .rdata1(rs2_val)
    );

    rv_alu rv_alu_i (
        .alu_op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result)
    );

    rv_control rv_control_i (
        .clk(clk), .rst(rst), .opcode(opcode), .funct3(funct3), .alt_bit(alt_bit),
        .rd(rd), .imm(imm), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .pc(instr_addr), .pc_plus4(pc_plus4), .alu_result(alu_result),
        .data_rdata(data_rdata), .load_instr(load_instr), .rf_we(rf_we),
        .rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .alu_op(alu_op),
        .alu_a(alu_a), .alu_b(alu_b), .pc_mode(pc_mode), .pc_target(pc_target),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_store(data_store)
    );

endmodule

// ==== verification/rv_core_tb.sv ====
module rv_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t code_base = 32'h800;
    localparam addr_t data_base = 32'h1000;
    localparam word_t nop_word  = 32'h0000_0013; // addi x0, x0, 0.
    localparam word_t val1      = 32'hffff_fffb; // x1 holds -5.
    localparam word_t val2      = 32'd3;         // x2 holds 3.

    logic  clk;
    logic  rst;
    addr_t instr_addr;
    word_t instr;
    addr_t data_addr;
    word_t data_wdata;
    logic  data_store;
    word_t data_rdata;

    word_t       imem [0:127];
    word_t       dmem [0:127];
    int          prog_len;
    logic [11:0] store_off;
    addr_t       end_addr;
    string       exp_name [$];
    addr_t       exp_addr [$];
    word_t       exp_data [$];

    rv_multi_cycle_core #(.start_addr(code_base)) rv_multi_cycle_core_i (
        .clk(clk), .rst(rst), .instr_addr(instr_addr), .instr(instr),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_store(data_store),
        .data_rdata(data_rdata)
    );

    always #4 clk = ~clk;

    // code lives at 0x800..0x9ff, data at 0x1000..0x11ff.
    assign instr = (instr_addr[31:9] === 23'h4) ? imem[instr_addr[8:2]] : nop_word;
    assign data_rdata = (data_addr[31:9] === 23'h8) ? dmem[data_addr[8:2]] : 32'h0;

    always @(posedge clk) begin
        if (data_store === 1'b1 && data_addr[31:9] == 23'h8) begin
            dmem[data_addr[8:2]] <= data_wdata;
        end
    end

    function automatic word_t fill_word(input addr_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t r_word(input logic [6:0] f7, input funct3_t f3,
                                     input reg_idx_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_word(input opcode_t opc, input funct3_t f3,
                                     input reg_idx_t rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_word(input reg_idx_t rs1, rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_word(input funct3_t f3, input reg_idx_t rs1, rs2,
                                     input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t u_word(input opcode_t opc, input reg_idx_t rd,
                                     input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_word(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t bool_word(input logic c);
        return {31'b0, c};
    endfunction

    // vacated upper bits take the sign bit.
    function automatic word_t arith_shift(input word_t v, input logic [4:0] s);
        return (v >> s) | (v[31] ? ~(32'hffff_ffff >> s) : 32'h0);
    endfunction

    function automatic word_t reg_value(input reg_idx_t idx);
        return (idx == 5'd1) ? val1 : val2;
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input word_t ra, rb);
        case (f3)
            F3_BEQ:  return ra == rb;
            F3_BNE:  return ra != rb;
            F3_BLT:  return $signed(ra) < $signed(rb);
            F3_BGE:  return $signed(ra) >= $signed(rb);
            F3_BLTU: return ra < rb;
            F3_BGEU: return ra >= rb;
            default: return 1'b0;
        endcase
    endfunction

    function automatic addr_t current_pc();
        return code_base + 4 * prog_len;
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // every SW goes to its own slot above 0x1100, whether it runs or not.
    task automatic store_result(input string name, input reg_idx_t rs, input word_t value,
                                input logic present);
        emit(s_word(5'd31, rs, store_off));
        if (present) begin
            exp_name.push_back(name);
            exp_addr.push_back(data_base + {20'b0, store_off});
            exp_data.push_back(value);
        end
        store_off = store_off + 12'd4;
    endtask

    task automatic run_and_store(input string name, input word_t w, input word_t value);
        emit(w);
        store_result(name, 5'd10, value, 1'b1);
    endtask

    // a taken branch jumps over the marker store.
    task automatic branch_over_marker(input string name, input funct3_t f3,
                                      input reg_idx_t rs1, rs2, input logic [11:0] marker);
        emit(i_word(OP_IMM, 3'b000, 5'd12, 5'd0, marker));
        emit(b_word(f3, rs1, rs2, 13'd8));
        store_result(name, 5'd12, {20'b0, marker},
                     !branch_taken(f3, reg_value(rs1), reg_value(rs2)));
    endtask

    task automatic build_program();
        addr_t p;
        prog_len  = 0;
        store_off = 12'h100;
        for (int i = 0; i < 128; i++) begin
            imem[i] = nop_word;
            dmem[i] = fill_word(data_base + 4 * i);
        end
        emit(u_word(OP_LUI, 5'd31, 20'h00001));
        store_result("lui base", 5'd31, data_base, 1'b1);
        emit(i_word(OP_IMM, 3'b000, 5'd1, 5'd0, 12'hffb));
        emit(i_word(OP_IMM, 3'b000, 5'd2, 5'd0, 12'h003));
        run_and_store("add", r_word(7'h00, 3'b000, 5'd10, 5'd1, 5'd2), val1 + val2);
        run_and_store("sub", r_word(7'h20, 3'b000, 5'd10, 5'd2, 5'd1), val2 - val1);
        run_and_store("sll", r_word(7'h00, 3'b001, 5'd10, 5'd1, 5'd2), val1 << 3);
        run_and_store("slt", r_word(7'h00, 3'b010, 5'd10, 5'd1, 5'd2), bool_word(1'b1));
        run_and_store("sltu", r_word(7'h00, 3'b011, 5'd10, 5'd1, 5'd2), bool_word(1'b0));
        run_and_store("xor", r_word(7'h00, 3'b100, 5'd10, 5'd1, 5'd2), val1 ^ val2);
        run_and_store("srl", r_word(7'h00, 3'b101, 5'd10, 5'd1, 5'd2), val1 >> 3);
        run_and_store("sra", r_word(7'h20, 3'b101, 5'd10, 5'd1, 5'd2), arith_shift(val1, 3));
        run_and_store("or", r_word(7'h00, 3'b110, 5'd10, 5'd1, 5'd2), val1 | val2);
        run_and_store("and", r_word(7'h00, 3'b111, 5'd10, 5'd1, 5'd2), val1 & val2);
        run_and_store("addi", i_word(OP_IMM, 3'b000, 5'd10, 5'd1, 12'd100), val1 + 32'd100);
        run_and_store("slti", i_word(OP_IMM, 3'b010, 5'd10, 5'd1, 12'hffd), bool_word(1'b1));
        run_and_store("sltiu", i_word(OP_IMM, 3'b011, 5'd10, 5'd2, 12'hfff), bool_word(1'b1));
        run_and_store("xori", i_word(OP_IMM, 3'b100, 5'd10, 5'd1, 12'h0f0), val1 ^ 32'h0f0);
        run_and_store("ori", i_word(OP_IMM, 3'b110, 5'd10, 5'd2, 12'hf00), val2 | 32'hffff_ff00);
        run_and_store("andi", i_word(OP_IMM, 3'b111, 5'd10, 5'd1, 12'h07f), val1 & 32'h7f);
        run_and_store("slli", i_word(OP_IMM, 3'b001, 5'd10, 5'd1, 12'h004), val1 << 4);
        run_and_store("srli", i_word(OP_IMM, 3'b101, 5'd10, 5'd1, 12'h01c), val1 >> 28);
        run_and_store("srai", i_word(OP_IMM, 3'b101, 5'd10, 5'd1, 12'h401), arith_shift(val1, 1));
        run_and_store("lui", u_word(OP_LUI, 5'd10, 20'habcde), 32'habcd_e000);
        p = current_pc();
        run_and_store("auipc", u_word(OP_AUIPC, 5'd10, 20'h12345), p + 32'h1234_5000);
        p = current_pc();
        emit(j_word(5'd10, 21'd8));
        emit(i_word(OP_IMM, 3'b000, 5'd10, 5'd0, 12'h000)); // skipped by the jump.
        store_result("jal link", 5'd10, p + 32'd4, 1'b1);
        p = current_pc();
        emit(u_word(OP_AUIPC, 5'd11, 20'h00000));
        emit(i_word(OP_JALR, 3'b000, 5'd10, 5'd11, 12'd13)); // the odd target loses bit 0.
        emit(i_word(OP_IMM, 3'b000, 5'd10, 5'd0, 12'h000));
        store_result("jalr link", 5'd10, p + 32'd8, 1'b1);
        branch_over_marker("beq taken", F3_BEQ, 5'd1, 5'd1, 12'd1);
        branch_over_marker("beq not taken", F3_BEQ, 5'd1, 5'd2, 12'd2);
        branch_over_marker("bne taken", F3_BNE, 5'd1, 5'd2, 12'd3);
        branch_over_marker("bne not taken", F3_BNE, 5'd1, 5'd1, 12'd4);
        branch_over_marker("blt taken", F3_BLT, 5'd1, 5'd2, 12'd5);
        branch_over_marker("blt not taken", F3_BLT, 5'd2, 5'd1, 12'd6);
        branch_over_marker("bge taken", F3_BGE, 5'd2, 5'd1, 12'd7);
        branch_over_marker("bge not taken", F3_BGE, 5'd1, 5'd2, 12'd8);
        branch_over_marker("bltu taken", F3_BLTU, 5'd2, 5'd1, 12'd9);
        branch_over_marker("bltu not taken", F3_BLTU, 5'd1, 5'd2, 12'd10);
        branch_over_marker("bgeu taken", F3_BGEU, 5'd1, 5'd2, 12'd11);
        branch_over_marker("bgeu not taken", F3_BGEU, 5'd2, 5'd1, 12'd12);
        run_and_store("lw preload 0", i_word(OP_LOAD, 3'b010, 5'd10, 5'd31, 12'h000),
                      fill_word(data_base));
        run_and_store("lw preload 44", i_word(OP_LOAD, 3'b010, 5'd10, 5'd31, 12'h044),
                      fill_word(data_base + 32'h44));
        run_and_store("lw stored add", i_word(OP_LOAD, 3'b010, 5'd10, 5'd31, 12'h104),
                      val1 + val2);
        emit(i_word(OP_IMM, 3'b000, 5'd0, 5'd1, 12'd99));
        store_result("x0 after addi", 5'd0, 32'h0, 1'b1);
        emit(r_word(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
        store_result("x0 after add", 5'd0, 32'h0, 1'b1);
        end_addr = current_pc();
        emit(j_word(5'd0, 21'd0));
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    // called one step after the edge that enters the first FETCH.
    task automatic measure_fetch_spacing();
        int cycles;
        cycles = 0;
        while (instr_addr === code_base && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value("fetch spacing", 32'd5, word_t'(cycles));
        check_value("second fetch", code_base + 32'd4, instr_addr);
    endtask

    task automatic await_store(input string name);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 200 && !seen; n++) begin
            @(posedge clk);
            #1;
            seen = (data_store === 1'b1);
        end
        if (!seen) begin
            report_failure($sformatf("no store for %s within 200 cycles", name));
        end
    endtask

    task automatic reach_self_loop();
        logic at_end;
        at_end = 1'b0;
        for (int n = 0; n < 100 && !at_end; n++) begin
            @(posedge clk);
            #1;
            if (data_store === 1'b1) begin
                report_failure("a store happened after the last expected one");
            end
            at_end = (instr_addr === end_addr);
        end
        if (!at_end) begin
            report_failure("the fetch address never reached the final loop");
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        build_program();
        repeat (8) @(posedge clk);
        #1;
        check_value("reset pc", code_base, instr_addr);
        check_value("store idle in reset", 32'h0, {31'b0, data_store});
        rst = 1'b0;
        @(posedge clk);
        #1;
        measure_fetch_spacing();
        for (int i = 0; i < exp_addr.size(); i++) begin
            await_store(exp_name[i]);
            check_value({exp_name[i], " addr"}, exp_addr[i], data_addr);
            check_value({exp_name[i], " data"}, exp_data[i], data_wdata);
        end
        reach_self_loop();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== rv_multi_cycle_core.f ====
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_pc.sv
hdl/rv_control.sv
hdl/rv_multi_cycle_core.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_multi_cycle_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_regfile.sv
  - hdl/rv_alu.sv
  - hdl/rv_pc.sv
  - hdl/rv_control.sv
  - hdl/rv_multi_cycle_core.sv

  - target: simulation
    files:
      - verification/rv_core_tb.sv
